// ==== Makefile ====
TOOL       = verilator
TOP        = board_top_tb
FILELIST   = filelist.f
BUILD_DIR  = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/board_top_props.sv ====
// bound assertions on the board top level's start-up flag, cpu status and channel duties
module board_top_props import selftest_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  run,
    input cpu_status_t           status,
    input duty_t [LED_CHANS-1:0] duty
);

    // start-up flag sticks until the next reset
    run_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && $past(run)) |-> run
    ) else $error("run fell while reset was released");

    // cpu only runs after the start-up delay
    running_needs_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        !run |-> !status.running
    ) else $error("cpu running while run is low");

    // halt result held, the halt edge itself is excluded
    passed_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && !$past(status.running) && !status.running) |-> $stable(status.passed)
    ) else $error("passed changed while the cpu was not running");

    // one lit colour at a time
    one_colour: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({duty[CH_RED] != '0, duty[CH_GREEN] != '0, duty[CH_BLUE] != '0})
    ) else $error("more than one led channel has a nonzero duty");

endmodule

// ==== bench/board_top_tb.sv ====
// testbench that runs a pad scenario table against the rgb pins of the board self-test top level
module board_top_tb import selftest_pkg::*; ();

    localparam int RESET_CYCLES   = 10;
    localparam int DRIVE_DELAY    = 10;             // after the rising edge
    localparam int WINDOW         = 1 << PWM_BITS;  // one pwm period
    localparam int MAX_DUTY       = WINDOW - 1;     // largest duty_t value
    localparam int RUN_WAIT_MAX   = 200;            // longest program is about 110 cycles
    localparam int SETTLE_WINDOWS = 6;
    localparam int NUM_ROWS       = 7;
    // 7 rows of reset, start-up, program and up to 3 pwm windows is about 6700 cycles
    localparam int TIMEOUT_CYCLES = 8000;

    // one scenario row
    typedef struct packed {
        logic [PAD_BITS-1:0] pads;
        logic                expect_pass;
        logic [3:0]          hold;      // extra reset cycles
        logic                abort;     // reset while the cpu runs
    } scenario_t;

    logic                clk;
    logic                rst_n;
    logic [PAD_BITS-1:0] pads;
    logic [2:0]          rgb;
    int                  cycle_cnt;
    int                  seed;
    scenario_t           scenarios [NUM_ROWS];

    board_top board_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .pads  (pads),
        .rgb   (rgb)
    );

    bind board_top board_top_props props_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .status (status),
        .duty   (duty)
    );

    always #50 clk = ~clk;  // period 100

    // global run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_failure();
        end
    end

    function automatic scenario_t build_row(input logic [PAD_BITS-1:0] pad_val,
                                            input logic [3:0] hold,
                                            input logic abort);
        scenario_t row;
        row.pads        = pad_val;
        row.expect_pass = (int'(pad_val) == SELFTEST_KEY);   // pass only on the key
        row.hold        = hold;
        row.abort       = abort;
        return row;
    endfunction

    // high count as a duty where a stuck-high pin reads as full scale
    function automatic duty_t count_to_duty(input int count);
        return (count > MAX_DUTY) ? duty_t'(MAX_DUTY) : duty_t'(count);
    endfunction

    task automatic report_failure();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_duty(input string name, input duty_t got, input duty_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_status(input string name, input cpu_status_t got,
                                input cpu_status_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_pins(input string name, input logic [2:0] got,
                              input logic [2:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
            report_failure();
        end
    endtask

    // drive point a little after the edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic wait_running(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (board_top_inst.status.running !== level) begin
            if (n >= max_cycles) begin
                $display("cpu running did not go to %0b within %0d cycles", level, max_cycles);
                report_failure();
            end
            @(negedge clk);
            n++;
        end
    endtask

    // high counts per pin over one full pwm period
    task automatic measure_window(output int red_hi, output int green_hi, output int blue_hi);
        red_hi   = 0;
        green_hi = 0;
        blue_hi  = 0;
        repeat (WINDOW) begin
            @(negedge clk);                 // pins stable mid-cycle
            red_hi   += int'(rgb[CH_RED]);
            green_hi += int'(rgb[CH_GREEN]);
            blue_hi  += int'(rgb[CH_BLUE]);
        end
    endtask

    // windows until a colour is lit and two windows in a row agree on every pin
    task automatic measure_settled(output int red_hi, output int green_hi, output int blue_hi);
        int prev_r;
        int prev_g;
        int prev_b;
        bit settled;
        prev_r  = -1;
        prev_g  = -1;
        prev_b  = -1;
        settled = 1'b0;
        for (int w = 0; w < SETTLE_WINDOWS && !settled; w++) begin
            measure_window(red_hi, green_hi, blue_hi);
            settled = (red_hi + green_hi > 0) && (red_hi == prev_r)
                      && (green_hi == prev_g) && (blue_hi == prev_b);
            prev_r = red_hi;
            prev_g = green_hi;
            prev_b = blue_hi;
        end
        if (!settled) begin
            $display("led colour did not settle within %0d pwm windows", SETTLE_WINDOWS);
            report_failure();
        end
    endtask

    task automatic run_row(input scenario_t row);
        int          red_hi;
        int          green_hi;
        int          blue_hi;
        cpu_status_t seen;
        cpu_status_t want;
        // reset with this row's pads already applied
        next_cycle();
        rst_n = 1'b0;
        pads  = row.pads;
        repeat (RESET_CYCLES + int'(row.hold)) next_cycle();
        @(negedge clk);
        check_pins("rgb in reset", rgb, 3'b000);
        next_cycle();
        rst_n = 1'b1;
        // start-up hold keeps every pin dark
        repeat (STARTUP_CYCLES) begin
            @(negedge clk);
            check_pins("rgb during start-up", rgb, 3'b000);
        end
        wait_running(1'b1, RUN_WAIT_MAX);
        @(negedge clk);
        // program ends inside the first pwm period so blue is checked at the mapper
        check_duty("duty[blue] while running", board_top_inst.duty[CH_BLUE], RUN_DUTY);
        check_duty("duty[green] while running", board_top_inst.duty[CH_GREEN], duty_t'(0));
        check_duty("duty[red] while running", board_top_inst.duty[CH_RED], duty_t'(0));
        if (row.abort) begin
            next_cycle();
            rst_n = 1'b0;                   // mid-run reset
            next_cycle();
            @(negedge clk);
            check_status("status after mid-run reset", board_top_inst.status, '0);
            check_pins("rgb after mid-run reset", rgb, 3'b000);
            return;
        end
        wait_running(1'b0, RUN_WAIT_MAX);
        measure_settled(red_hi, green_hi, blue_hi);
        // colour decoded back to a status
        want.running = 1'b0;
        want.passed  = row.expect_pass;
        seen.running = (blue_hi != 0);
        seen.passed  = (green_hi != 0);
        check_status("led colour", seen, want);
        check_duty("blue high count", count_to_duty(blue_hi), duty_t'(0));
        check_duty("green high count", count_to_duty(green_hi),
                   row.expect_pass ? PASS_DUTY : duty_t'(0));
        check_duty("red high count", count_to_duty(red_hi),
                   row.expect_pass ? duty_t'(0) : FAIL_DUTY);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        pads      = '0;
        cycle_cnt = 0;
        seed      = 32'hc87a;
        // pads, reset hold, abort
        scenarios[0] = build_row(4'd0, 4'd0, 1'b0);     // loop skipped and fails
        scenarios[1] = build_row(4'd10, 4'd3, 1'b0);    // the key
        scenarios[2] = build_row(4'd10, 4'd1, 1'b1);    // key cut short by reset
        scenarios[3] = build_row(4'd9, 4'd5, 1'b0);     // one short
        scenarios[4] = build_row(4'd15, 4'd0, 1'b0);    // longest loop
        scenarios[5] = build_row(PAD_BITS'($random(seed)), 4'd2, 1'b0);
        scenarios[6] = build_row(PAD_BITS'($random(seed)), 4'd7, 1'b0);
        foreach (scenarios[i]) begin
            run_row(scenarios[i]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== design/board_top.sv ====
// board self-test top level with start-up delay, cpu, colour mapper and rgb dimmers
module board_top import selftest_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [PAD_BITS-1:0] pads,
    output logic [2:0]          rgb
);

    logic                  run;         // start-up done
    cpu_status_t           status;      // running, passed
    duty_t [LED_CHANS-1:0] duty;        // per channel duty, red green blue

    startup_delay u_startup (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run)
    );

    cpu u_cpu (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .pads   (pads),
        .status (status)
    );

    status_color u_color (
        .clk    (clk),
        .rst_n  (rst_n),
        .status (status),
        .duty   (duty)
    );

    // one dimmer per channel, pin index equals channel index
    for (genvar ch = CH_RED; ch <= CH_BLUE; ch++) begin : g_chan
        led_pwm u_pwm (
            .clk   (clk),
            .rst_n (rst_n),
            .duty  (duty[ch]),
            .led   (rgb[ch])
        );
    end

endmodule

// ==== design/cpu.sv ====
// accumulator cpu that runs the rom self-test and reports running and passed
module cpu import selftest_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  logic [PAD_BITS-1:0] pads,
    output cpu_status_t         status
);

    cpu_state_e           state_q;
    logic [PC_BITS-1:0]   pc_q;
    logic [PC_BITS-1:0]   pc_inc;       // sequential next pc
    logic [PC_BITS-1:0]   br_target;    // branch target from operand
    cpu_instr_t           rom_instr;    // word at pc in the same cycle
    cpu_instr_t           instr_q;      // word latched in FETCH
    logic [DATA_BITS-1:0] acc_q;        // accumulator
    logic [DATA_BITS-1:0] cnt_q;        // loop counter
    logic                 zero_q;       // cnt is zero
    logic                 eq_q;         // last compare matched
    cpu_status_t          status_q;

    cpu_rom u_rom (
        .pc    (pc_q),
        .instr (rom_instr)
    );

    assign pc_inc    = pc_q + PC_BITS'(1);
    assign br_target = instr_q.operand[PC_BITS-1:0];    // low operand bits index the 16 words

    // control path with state, pc, flags and status
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            pc_q     <= '0;
            zero_q   <= 1'b0;
            eq_q     <= 1'b0;
            status_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (run) begin
                        state_q          <= FETCH;
                        status_q.running <= 1'b1;   // high the cycle after run seen
                    end
                end

                FETCH: begin
                    state_q <= EXEC;                // rom word latched below
                end

                EXEC: begin
                    state_q <= FETCH;
                    pc_q    <= pc_inc;
                    case (instr_q.op)
                        LDPAD: begin
                            zero_q <= (pads == '0);
                        end
                        DEC: begin
                            zero_q <= (cnt_q == DATA_BITS'(1));    // cnt about to hit 0
                        end
                        CMPI: begin
                            eq_q <= (acc_q == instr_q.operand);
                        end
                        JNZ: begin
                            if (!zero_q) begin
                                pc_q <= br_target;
                            end
                        end
                        BEQ: begin
                            if (eq_q) begin
                                pc_q <= br_target;
                            end
                        end
                        HALT_PASS: begin
                            state_q          <= DONE;
                            status_q.running <= 1'b0;
                            status_q.passed  <= 1'b1;
                        end
                        HALT_FAIL: begin
                            state_q          <= DONE;
                            status_q.running <= 1'b0;
                            status_q.passed  <= 1'b0;
                        end
                        default: begin
                            // NOP, LDI, ADDI touch datapath only
                        end
                    endcase
                end

                DONE: begin
                    state_q <= DONE;                // hold status until reset
                end

                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // datapath with the rom word latch, accumulator and counter
    always_ff @(posedge clk) begin
        if (state_q == FETCH) begin
            instr_q <= rom_instr;
        end
        if (state_q == EXEC) begin
            case (instr_q.op)
                LDI:     acc_q <= instr_q.operand;
                ADDI:    acc_q <= acc_q + instr_q.operand;     // wraps at 8 bits
                LDPAD:   cnt_q <= DATA_BITS'(pads);            // only pad sample
                DEC:     cnt_q <= cnt_q - 1'b1;
                default: begin
                end
            endcase
        end
    end

    assign status = status_q;

endmodule

// ==== design/cpu_rom.sv ====
// self-test program rom for the accumulator cpu, read combinationally by pc
module cpu_rom import selftest_pkg::*; (
    input  logic [PC_BITS-1:0] pc,
    output cpu_instr_t         instr
);

    // program flow
    //   cnt = pads, acc = 0
    //   zero pads skip the loop by forcing eq with a compare against 0
    //   loop adds LOOP_STEP per pass until cnt is zero
    //   acc compared with LOOP_STEP * SELFTEST_KEY picks the halt
    always_comb begin
        case (pc)
            4'd0:    instr = '{op: LDPAD,     operand: 8'd0};           // cnt <= pads
            4'd1:    instr = '{op: LDI,       operand: 8'd0};           // clear acc
            4'd2:    instr = '{op: JNZ,       operand: 8'd5};           // nonzero pads, loop
            4'd3:    instr = '{op: CMPI,      operand: 8'd0};           // acc is 0, eq set
            4'd4:    instr = '{op: BEQ,       operand: 8'd8};           // always taken here
            4'd5:    instr = '{op: ADDI,      operand: DATA_BITS'(LOOP_STEP)}; // loop body
            4'd6:    instr = '{op: DEC,       operand: 8'd0};
            4'd7:    instr = '{op: JNZ,       operand: 8'd5};           // back to loop body
            4'd8:    instr = '{op: CMPI,      operand: EXPECT_ACC};     // check result
            4'd9:    instr = '{op: BEQ,       operand: 8'd11};
            4'd10:   instr = '{op: HALT_FAIL, operand: 8'd0};
            4'd11:   instr = '{op: HALT_PASS, operand: 8'd0};
            4'd12:   instr = '{op: NOP,       operand: 8'd0};           // spare words
            4'd13:   instr = '{op: NOP,       operand: 8'd0};
            default: instr = '{op: HALT_FAIL, operand: 8'd0};           // runaway pc fails
        endcase
    end

endmodule

// ==== design/led_pwm.sv ====
// led pwm dimmer channel with a free-running counter and a per-period duty compare
module led_pwm import selftest_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  duty_t duty,
    output logic  led
);

    logic [PWM_BITS-1:0] pwm_cnt;   // free-running, 256 cycle period
    duty_t               cmp_q;     // duty held for a whole period
    logic                led_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
            cmp_q   <= '0;
            led_q   <= 1'b0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            if (pwm_cnt == '1) begin
                cmp_q <= duty;              // new duty takes effect at count 0
            end
            led_q <= (pwm_cnt < cmp_q);     // high for cmp_q counts per period
        end
    end

    // registered output, no glitches on the pin
    assign led = led_q;

endmodule

// ==== design/selftest_pkg.sv ====
// self-test package with the cpu opcodes, status types and board constants
package selftest_pkg;

    // start-up sequencer
    localparam int STARTUP_CYCLES = 64;                     // idle delay after reset
    localparam int STARTUP_BITS   = $clog2(STARTUP_CYCLES) + 1; // top bit is the run flag

    // program store and datapath
    localparam int ROM_DEPTH = 16;                          // rom words
    localparam int PC_BITS   = $clog2(ROM_DEPTH);           // 4 bit pc
    localparam int DATA_BITS = 8;                           // acc, counter and operand width
    localparam int PAD_BITS  = 4;                           // touch pads

    // self-test program constants
    localparam int SELFTEST_KEY = 10;                       // pad value that passes
    localparam int LOOP_STEP    = 3;                        // added per loop pass
    localparam logic [DATA_BITS-1:0] EXPECT_ACC = DATA_BITS'(LOOP_STEP * SELFTEST_KEY);

    // led dimmers
    localparam int PWM_BITS  = 8;                           // pwm counter width
    localparam int LED_CHANS = 3;                           // red, green, blue

    typedef logic [PWM_BITS-1:0] duty_t;

    localparam duty_t RUN_DUTY  = duty_t'(64);              // blue while running
    localparam duty_t PASS_DUTY = duty_t'(128);             // green after pass
    localparam duty_t FAIL_DUTY = duty_t'(200);             // red after fail

    // channel index, also the rgb pin index
    typedef enum logic [1:0] {
        CH_RED   = 2'd0,
        CH_GREEN = 2'd1,
        CH_BLUE  = 2'd2
    } led_chan_e;

    typedef enum logic [3:0] {
        NOP       = 4'd0,   // no operation
        LDI       = 4'd1,   // acc <= operand
        ADDI      = 4'd2,   // acc <= acc + operand
        DEC       = 4'd3,   // cnt <= cnt - 1, sets zero
        JNZ       = 4'd4,   // branch if cnt nonzero
        CMPI      = 4'd5,   // eq <= acc == operand
        HALT_PASS = 4'd6,   // stop with passed set
        HALT_FAIL = 4'd7,   // stop with passed clear
        LDPAD     = 4'd8,   // cnt <= pads, sets zero
        BEQ       = 4'd9    // branch if eq
    } cpu_op_e;

    // one rom word, 12 bits
    typedef struct packed {
        cpu_op_e               op;
        logic [DATA_BITS-1:0]  operand;
    } cpu_instr_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,       // waiting for run
        FETCH = 2'd1,       // latch rom word
        EXEC  = 2'd2,       // execute latched word
        DONE  = 2'd3        // halted until reset
    } cpu_state_e;

    typedef struct packed {
        logic running;
        logic passed;
    } cpu_status_t;

endpackage

// ==== design/startup_delay.sv ====
// start-up sequencer that holds the cpu idle for a fixed number of cycles after reset
module startup_delay import selftest_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    output logic run
);

    logic [STARTUP_BITS-1:0] wait_cnt;  // top bit set after STARTUP_CYCLES edges

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (!wait_cnt[STARTUP_BITS-1]) begin
            wait_cnt <= wait_cnt + 1'b1;    // stops once top bit is set
        end
    end

    // counter freezes with top bit high, so run sticks until reset
    assign run = wait_cnt[STARTUP_BITS-1];

endmodule

// ==== design/status_color.sv ====
// status to colour mapper that turns cpu status into one duty per led channel
module status_color import selftest_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_status_t            status,
    output duty_t [LED_CHANS-1:0]  duty
);

    duty_t [LED_CHANS-1:0] duty_q;
    logic                  seen_run;    // running has been high since reset

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty_q   <= '0;
            seen_run <= 1'b0;
        end else begin
            duty_q <= '0;                           // unlit by default
            if (status.running) begin
                seen_run         <= 1'b1;
                duty_q[CH_BLUE]  <= RUN_DUTY;
            end else if (seen_run) begin
                if (status.passed) begin
                    duty_q[CH_GREEN] <= PASS_DUTY;
                end else begin
                    duty_q[CH_RED]   <= FAIL_DUTY;
                end
            end
        end
    end

    assign duty = duty_q;   // one cycle behind status

endmodule

// ==== filelist.f ====
design/selftest_pkg.sv
design/startup_delay.sv
design/cpu_rom.sv
design/cpu.sv
design/status_color.sv
design/led_pwm.sv
design/board_top.sv
bench/board_top_props.sv
bench/board_top_tb.sv
